// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_serial_port
FILELIST  := serial_port.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: serial_port.f
source/serial_pkg.sv
source/serial_cmd_decode.sv
source/serial_bit_timer.sv
source/serial_write_buffer.sv
source/serial_read_buffer.sv
source/serial_port.sv
tb/tb_clock_gen.sv
tb/tb_serial_port.sv

// File: source/serial_bit_timer.sv
// CLK_DIV must be even and at least 2; sclk idles low and rises mid bit, after the sample strobe
`timescale 1ns/10ps

module serial_bit_timer #(
	parameter int CLK_DIV = 4
) (
	input  logic sys_clk,
	input  logic rst,
	input  logic start,
	input  logic stop,
	output logic bit_strobe,
	output logic sample_strobe,
	output logic sclk
);

	localparam int phase_w = (CLK_DIV > 2) ? $clog2(CLK_DIV) : 1;

	typedef logic [phase_w-1:0] phase_t;

	logic   run;
	logic   run_next;
	phase_t phase;
	phase_t phase_next;

	// phase counts through a bit period that ends at phase 0
	always_comb begin
		run_next   = run;
		phase_next = phase;
		if (stop) begin
			run_next   = 1'b0;
			phase_next = '0;
		end else if (start) begin
			// first cycle after start is phase 1
			run_next   = 1'b1;
			phase_next = phase_t'(1);
		end else if (run) begin
			if (phase == phase_t'(CLK_DIV - 1))
				phase_next = '0;
			else
				phase_next = phase + phase_t'(1);
		end
	end

	// outputs registered from the next phase so they line up with it
	always_ff @(posedge sys_clk or posedge rst) begin
		if (rst) begin
			run           <= 1'b0;
			phase         <= '0;
			bit_strobe    <= 1'b0;
			sample_strobe <= 1'b0;
			sclk          <= 1'b0;
		end else begin
			run           <= run_next;
			phase         <= phase_next;
			bit_strobe    <= run_next && (phase_next == '0);
			sample_strobe <= run_next && (phase_next == phase_t'(CLK_DIV / 2));
			// high over the second half including phase 0
			sclk <= run_next && ((phase_next == '0) ||
				(phase_next > phase_t'(CLK_DIV / 2)));
		end
	end

	// each bit period is sampled half a period before it ends
	a_sample_before_bit: assert property (@(posedge sys_clk) disable iff (rst)
		bit_strobe |-> $past(sample_strobe, CLK_DIV / 2));

endmodule

// File: source/serial_cmd_decode.sv
// accepts commands only while idle; counts outside 1..buf_size raise cmd_error and start nothing
`timescale 1ns/10ps

module serial_cmd_decode (
	input  logic                    sys_clk,
	input  logic                    rst,
	input  serial_pkg::serial_cmd_t cmd,
	input  logic                    cmd_valid,
	input  logic                    done,
	output logic                    start,
	output serial_pkg::serial_cmd_t xfer,
	output logic                    busy,
	output logic                    cmd_error
);

	typedef enum logic {
		st_idle,
		st_busy
	} state_t;

	state_t state;
	logic   count_ok;
	logic   accept;

	// count must be nonzero and fit the buffer
	assign count_ok = (cmd.count != '0) &&
		(cmd.count <= serial_pkg::count_t'(serial_pkg::buf_size));

	// cmd_valid while busy falls through here
	assign accept = (state == st_idle) && cmd_valid && count_ok;

	assign busy = (state == st_busy);

	always_ff @(posedge sys_clk or posedge rst) begin
		if (rst) begin
			state     <= st_idle;
			start     <= 1'b0;
			cmd_error <= 1'b0;
		end else begin
			// both are single cycle pulses
			start     <= 1'b0;
			cmd_error <= 1'b0;
			case (state)
				st_idle: begin
					if (accept) begin
						start <= 1'b1;
						state <= st_busy;
					end else if (cmd_valid) begin
						cmd_error <= 1'b1;
					end
				end
				st_busy: begin
					// write buffer has sent its last bit
					if (done)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// held for the whole transfer, both buffers read it on start
	always_ff @(posedge sys_clk) begin
		if (accept)
			xfer <= cmd;
	end

	a_start_err_excl: assert property (@(posedge sys_clk) disable iff (rst)
		!(start && cmd_error));

	// done must come from a transfer this decoder started
	a_done_in_busy: assert property (@(posedge sys_clk) disable iff (rst)
		done |-> (state == st_busy));

endmodule

// File: source/serial_pkg.sv
// shared widths and types for the serial port; buf_size caps one transfer, counts run 0..buf_size
package serial_pkg;

	// most bits a single transfer can carry
	localparam int buf_size = 16;

	// enough bits to hold 0..buf_size inclusive
	localparam int count_w = $clog2(buf_size + 1);

	// data word, msb-aligned on the way out
	// right-aligned when it comes back as a result
	typedef logic [buf_size-1:0] data_t;

	// bit count of a transfer
	typedef logic [count_w-1:0] count_t;

	// command from the host
	// only the top count bits of data are sent
	typedef struct packed {
		count_t count;
		data_t  data;
	} serial_cmd_t;

	// result back to the host
	// data holds the sampled bits, last one in the lsb
	typedef struct packed {
		count_t count;
		data_t  data;
	} serial_result_t;

endpackage

// File: source/serial_port.sv
// spi style master without chip select or cpol/cpha; host must wait for busy low before cmd_valid
`timescale 1ns/10ps

module serial_port #(
	parameter int CLK_DIV = 4
) (
	input  logic                       sys_clk,
	input  logic                       rst,
	input  serial_pkg::serial_cmd_t    cmd,
	input  logic                       cmd_valid,
	input  logic                       sdi,
	output logic                       busy,
	output logic                       cmd_error,
	output logic                       sdo,
	output logic                       sclk,
	output serial_pkg::serial_result_t result,
	output logic                       result_valid
);

	logic                    start;
	logic                    done;
	logic                    bit_strobe;
	logic                    sample_strobe;
	serial_pkg::serial_cmd_t xfer;

	// command check and busy level
	serial_cmd_decode u_decode (
		.sys_clk   (sys_clk),
		.rst       (rst),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.done      (done),
		.start     (start),
		.xfer      (xfer),
		.busy      (busy),
		.cmd_error (cmd_error)
	);

	// bit periods, runs until the write side is done
	serial_bit_timer #(
		.CLK_DIV (CLK_DIV)
	) u_timer (
		.sys_clk       (sys_clk),
		.rst           (rst),
		.start         (start),
		.stop          (done),
		.bit_strobe    (bit_strobe),
		.sample_strobe (sample_strobe),
		.sclk          (sclk)
	);

	serial_write_buffer u_write (
		.sys_clk    (sys_clk),
		.rst        (rst),
		.start      (start),
		.xfer       (xfer),
		.bit_strobe (bit_strobe),
		.sdo        (sdo),
		.done       (done)
	);

	serial_read_buffer u_read (
		.sys_clk       (sys_clk),
		.rst           (rst),
		.start         (start),
		.xfer          (xfer),
		.sample_strobe (sample_strobe),
		.sdi           (sdi),
		.result        (result),
		.result_valid  (result_valid)
	);

	// last sample lands before the final write strobe, so busy is still up
	a_result_in_busy: assert property (@(posedge sys_clk) disable iff (rst)
		result_valid |-> busy);

endmodule

// File: source/serial_read_buffer.sv
// samples xfer.count bits from sdi; result is right-aligned and holds until the next transfer ends
`timescale 1ns/10ps

module serial_read_buffer (
	input  logic                       sys_clk,
	input  logic                       rst,
	input  logic                       start,
	input  serial_pkg::serial_cmd_t    xfer,
	input  logic                       sample_strobe,
	input  logic                       sdi,
	output serial_pkg::serial_result_t result,
	output logic                       result_valid
);

	// bits still to sample
	serial_pkg::count_t remaining;

	// count of the running transfer
	serial_pkg::count_t count_q;

	// filled from the lsb end
	serial_pkg::data_t shift;
	serial_pkg::data_t shift_next;

	logic active;
	logic take;
	logic last;

	assign take = active && sample_strobe;
	assign last = take && (remaining == serial_pkg::count_t'(1));

	assign shift_next = {shift[serial_pkg::buf_size-2:0], sdi};

	// control
	always_ff @(posedge sys_clk or posedge rst) begin
		if (rst) begin
			active       <= 1'b0;
			remaining    <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			if (start) begin
				active    <= 1'b1;
				remaining <= xfer.count;
			end else if (take) begin
				remaining <= remaining - serial_pkg::count_t'(1);
				if (last) begin
					// late strobes are dropped from here on
					active       <= 1'b0;
					result_valid <= 1'b1;
				end
			end
		end
	end

	// payload
	always_ff @(posedge sys_clk) begin
		if (start) begin
			shift   <= '0;
			count_q <= xfer.count;
		end else if (take) begin
			shift <= shift_next;
		end
		if (!start && last) begin
			result.count <= count_q;
			result.data  <= shift_next;
		end
	end

endmodule

// File: source/serial_write_buffer.sv
// sends the top xfer.count bits of xfer.data msb first; start is only taken in the idle state
`timescale 1ns/10ps

module serial_write_buffer (
	input  logic                    sys_clk,
	input  logic                    rst,
	input  logic                    start,
	input  serial_pkg::serial_cmd_t xfer,
	input  logic                    bit_strobe,
	output logic                    sdo,
	output logic                    done
);

	typedef enum logic [1:0] {
		st_reset,
		st_idle,
		st_write
	} state_t;

	state_t state;

	// the msb goes to sdo right away and only the rest is kept here
	logic [serial_pkg::buf_size-2:0] write_buf;

	// bits still to go after the one on sdo
	serial_pkg::count_t ctr;

	always_ff @(posedge sys_clk or posedge rst) begin
		if (rst) begin
			state <= st_reset;
			sdo   <= 1'b0;
			done  <= 1'b0;
			ctr   <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				st_reset: begin
					// one pass through here clears the line
					sdo   <= 1'b0;
					ctr   <= '0;
					state <= st_idle;
				end
				st_idle: begin
					if (start) begin
						sdo   <= xfer.data[serial_pkg::buf_size-1];
						ctr   <= xfer.count - serial_pkg::count_t'(1);
						state <= st_write;
					end
				end
				st_write: begin
					if (bit_strobe) begin
						if (ctr == '0) begin
							// strobe after the last bit ends it
							done  <= 1'b1;
							sdo   <= 1'b0;
							state <= st_idle;
						end else begin
							sdo <= write_buf[serial_pkg::buf_size-2];
							ctr <= ctr - serial_pkg::count_t'(1);
						end
					end
				end
				default: state <= st_reset;
			endcase
		end
	end

	// remaining bits move up toward sdo
	always_ff @(posedge sys_clk) begin
		if (state == st_reset)
			write_buf <= '0;
		else if (state == st_idle && start)
			write_buf <= xfer.data[serial_pkg::buf_size-2:0];
		else if (state == st_write && bit_strobe)
			write_buf <= write_buf << 1;
	end

	// a new transfer may only start once the last one is done
	a_start_in_idle: assert property (@(posedge sys_clk) disable iff (rst)
		start |-> (state == st_idle));

endmodule

// File: tb/tb_clock_gen.sv
// free running sys_clk with a 4 ns period; rst is high from time 0 for reset_cycles rising edges
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int reset_cycles = 8
) (
	output logic sys_clk,
	output logic rst
);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// release lines up with a rising edge
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge sys_clk);
		rst <= 1'b0;
	end

endmodule

// File: tb/tb_serial_port.sv
// loopback test with CLK_DIV 4; sdi is the inverse of sdo, so each result is the inverted sent bits
`timescale 1ns/10ps

module tb_serial_port;

	localparam int clk_div      = 4;
	localparam int reset_cycles = 8;
	// 40 transfers of at most buf_size bits, plus slack per transfer
	localparam int timeout_cycles =
		40 * (serial_pkg::buf_size * clk_div + 10) + reset_cycles;

	logic                       sys_clk;
	logic                       rst;
	serial_pkg::serial_cmd_t    cmd;
	logic                       cmd_valid;
	logic                       sdi;
	logic                       busy;
	logic                       cmd_error;
	logic                       sdo;
	logic                       sclk;
	serial_pkg::serial_result_t result;
	logic                       result_valid;

	// expected results, oldest first
	serial_pkg::serial_result_t exp_q[$];

	// sdo at each sclk rise, first bit ends up highest
	serial_pkg::data_t  rec_bits  = '0;
	serial_pkg::count_t rec_count = '0;
	logic               sclk_q    = 1'b0;

	integer seed         = 32'h360b;
	int     cycles       = 0;
	int     error_pulses = 0;
	int     results_seen = 0;
	int     xfers_sent   = 0;

	tb_clock_gen #(.reset_cycles(reset_cycles)) u_clk (.sys_clk(sys_clk), .rst(rst));

	serial_port #(.CLK_DIV(clk_div)) u_dut (
		.sys_clk      (sys_clk),
		.rst          (rst),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.sdi          (sdi),
		.busy         (busy),
		.cmd_error    (cmd_error),
		.sdo          (sdo),
		.sclk         (sclk),
		.result       (result),
		.result_valid (result_valid)
	);

	// device model, echoes sdo inverted
	assign sdi = ~sdo;

	task automatic abort(input string line);
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1, "test stopped");
	endtask

	task automatic check_result(input serial_pkg::serial_result_t got,
		input serial_pkg::serial_result_t exp);
		if (got !== exp)
			abort($sformatf("ERROR at %0t: result count %0d data %h, expected count %0d data %h",
				$time, got.count, got.data, exp.count, exp.data));
	endtask

	task automatic check_bits(input serial_pkg::data_t got_bits, input serial_pkg::count_t got_n,
		input serial_pkg::data_t exp_bits, input serial_pkg::count_t exp_n);
		if (got_bits !== exp_bits || got_n !== exp_n)
			abort($sformatf("ERROR at %0t: sdo sent %0d bits %h, expected %0d bits %h",
				$time, got_n, got_bits, exp_n, exp_bits));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	// loopback inverts each bit, read side right-aligns what it sampled
	function automatic serial_pkg::serial_result_t expected_result(
		input serial_pkg::serial_cmd_t c);
		serial_pkg::serial_result_t r;
		int n;
		n       = int'(c.count);
		r.count = c.count;
		r.data  = '0;
		for (int i = 0; i < n; i++)
			r.data[i] = ~c.data[serial_pkg::buf_size - n + i];
		return r;
	endfunction

	// top count bits of the data word, right-aligned
	function automatic serial_pkg::data_t sent_bits(input serial_pkg::serial_cmd_t c);
		serial_pkg::data_t b;
		int n;
		n = int'(c.count);
		b = '0;
		for (int i = 0; i < n; i++)
			b[i] = c.data[serial_pkg::buf_size - n + i];
		return b;
	endfunction

	task automatic check_quiet();
		check_flag("busy", busy, 1'b0);
		check_flag("cmd_error", cmd_error, 1'b0);
		check_flag("result_valid", result_valid, 1'b0);
		check_flag("sdo", sdo, 1'b0);
		check_flag("sclk", sclk, 1'b0);
	endtask

	// starts the moment busy is low, so runs are back to back
	// poke sends a second command while busy, which must be dropped
	task automatic run_xfer(input serial_pkg::serial_cmd_t c, input logic poke);
		while (busy)
			@(posedge sys_clk);
		cmd       <= c;
		cmd_valid <= 1'b1;
		exp_q.push_back(expected_result(c));
		xfers_sent++;
		@(posedge sys_clk);
		cmd_valid <= 1'b0;
		if (poke) begin
			repeat (3) @(posedge sys_clk);
			check_flag("busy", busy, 1'b1);
			cmd       <= '{count: serial_pkg::count_t'(8), data: ~c.data};
			cmd_valid <= 1'b1;
			@(posedge sys_clk);
			cmd_valid <= 1'b0;
		end
		@(posedge sys_clk);
		while (busy)
			@(posedge sys_clk);
		if (exp_q.size() != 0)
			abort("no result_valid came before busy fell");
		check_bits(rec_bits, rec_count, sent_bits(c), c.count);
	endtask

	// count out of range, one error pulse and nothing else
	task automatic reject_cmd(input serial_pkg::count_t n);
		while (busy)
			@(posedge sys_clk);
		cmd.count <= n;
		cmd.data  <= serial_pkg::data_t'($random(seed));
		cmd_valid <= 1'b1;
		@(posedge sys_clk);
		cmd_valid <= 1'b0;
		@(posedge sys_clk);
		check_flag("cmd_error", cmd_error, 1'b1);
		check_flag("busy", busy, 1'b0);
		repeat (4) begin
			@(posedge sys_clk);
			check_quiet();
		end
	endtask

	// compare on result_valid, count error pulses
	always @(posedge sys_clk) begin
		if (!rst && cmd_error)
			error_pulses++;
		if (!rst && result_valid) begin
			if (exp_q.size() == 0)
				abort("result_valid came with no transfer pending");
			check_result(result, exp_q.pop_front());
			results_seen++;
		end
	end

	// sdo monitor, cleared when a command is offered while idle
	always @(posedge sys_clk) begin
		sclk_q <= sclk;
		if (rst || (cmd_valid && !busy)) begin
			rec_bits  <= '0;
			rec_count <= '0;
		end else if (sclk && !sclk_q) begin
			rec_bits  <= {rec_bits[serial_pkg::buf_size-2:0], sdo};
			rec_count <= rec_count + serial_pkg::count_t'(1);
		end
	end

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles > timeout_cycles)
			abort($sformatf("timeout: the run did not end within %0d cycles", timeout_cycles));
	end

	initial begin
		serial_pkg::serial_cmd_t c;
		cmd       = '0;
		cmd_valid = 1'b0;
		// quiet through reset and a few idle cycles
		repeat (reset_cycles + 4) begin
			@(posedge sys_clk);
			check_quiet();
		end
		run_xfer('{count: serial_pkg::count_t'(16), data: 16'hc5a3}, 1'b0);
		// single bit is the msb
		run_xfer('{count: serial_pkg::count_t'(1), data: 16'h8001}, 1'b0);
		run_xfer('{count: serial_pkg::count_t'(1), data: 16'h7ffe}, 1'b0);
		repeat (30) begin
			c.count = serial_pkg::count_t'(($random(seed) & 32'hf) + 1);
			c.data  = serial_pkg::data_t'($random(seed));
			run_xfer(c, 1'b0);
		end
		reject_cmd(serial_pkg::count_t'(0));
		reject_cmd(serial_pkg::count_t'(17));
		run_xfer('{count: serial_pkg::count_t'(12), data: 16'h9e37}, 1'b1);
		// a stray result_valid would show up here
		repeat (2 * serial_pkg::buf_size * clk_div) begin
			@(posedge sys_clk);
			check_quiet();
		end
		if (exp_q.size() != 0 || error_pulses != 2 || results_seen != xfers_sent) begin
			abort($sformatf("end counts wrong: %0d results for %0d transfers, %0d error pulses",
				results_seen, xfers_sent, error_pulses));
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule
